// File: Bender.yml
package:
  name: rename_core

sources:
  - src/core_types_pkg.sv
  - src/queue_pkg.sv
  - src/circular_queue.sv
  - src/rename_stage.sv
  - src/commit_stage.sv
  - src/rename_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/rename_tb.sv

// File: rename_core.f
+incdir+tests
src/core_types_pkg.sv
src/queue_pkg.sv
src/circular_queue.sv
src/rename_stage.sv
src/commit_stage.sv
src/rename_top.sv
tests/rename_tb.sv

// File: src/circular_queue.sv
`timescale 1ns/10ps

module circular_queue #(
    parameter type                        QUEUE_TYPE = logic [7:0],
    parameter queue_pkg::initialization_t INIT_TYPE  = queue_pkg::ZERO,
    parameter int unsigned                SS         = 2,
    parameter int unsigned                DEPTH      = 16
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   push,
    input  logic                                   pop,
    input  QUEUE_TYPE                              in             [SS],  // Bundle written at head
    input  QUEUE_TYPE                              reg_in         [SS],  // Bits set in an entry
    input  logic [queue_pkg::idx_width(DEPTH)-1:0] reg_select_in  [SS],
    input  logic [queue_pkg::idx_width(DEPTH)-1:0] reg_select_out [SS],
    input  logic [SS-1:0]                          in_bitmask,
    input  logic [SS-1:0]                          out_bitmask,
    output logic                                   empty,
    output logic                                   full,
    output logic [queue_pkg::idx_width(DEPTH)-1:0] head_out,
    output logic [queue_pkg::idx_width(DEPTH)-1:0] tail_out,
    output QUEUE_TYPE                              out            [SS],  // Popped bundle
    output QUEUE_TYPE                              reg_out        [SS]   // Observed entries
);
    import queue_pkg::*;

    localparam int unsigned IDX_W   = idx_width(DEPTH);
    localparam int unsigned PTR_W   = ptr_width(DEPTH);
    localparam int unsigned ENTRY_W = $bits(QUEUE_TYPE);

    QUEUE_TYPE        entries [DEPTH];
    logic [PTR_W-1:0] head;    // MSB is the wrap bit
    logic [PTR_W-1:0] tail;
    logic [PTR_W-1:0] count;

    if ((1 << IDX_W) != DEPTH) begin : g_depth_check
        $error("circular_queue: DEPTH must be a power of two");
    end

    assign head_out = head[IDX_W-1:0];
    assign tail_out = tail[IDX_W-1:0];
    assign count    = head - tail;
    assign empty    = (head == tail);
    assign full     = (32'(count) + SS > DEPTH);  // No room for one more bundle

    always_ff @(posedge clk) begin
        if (rst) begin
            tail <= '0;
            if (INIT_TYPE == FREE_LIST) begin
                head <= PTR_W'(DEPTH);  // Wrap bit set, queue starts full
                for (int i = 0; i < DEPTH; i++) begin
                    // Free registers sit just above the architectural ones
                    entries[i] <= QUEUE_TYPE'(ENTRY_W'(DEPTH + i));
                end
            end else begin
                head <= '0;
                for (int i = 0; i < DEPTH; i++) begin
                    entries[i] <= '0;
                end
            end
        end else begin
            if (push) begin
                head <= head + PTR_W'(SS);
                for (int k = 0; k < SS; k++) begin
                    entries[IDX_W'(head_out + k)] <= in[k];
                end
            end
            if (pop) begin
                tail <= tail + PTR_W'(SS);
            end
            // Modify port ORs bits in, so flags can be set without a read
            for (int k = 0; k < SS; k++) begin
                if (in_bitmask[k]) begin
                    entries[reg_select_in[k]] <= entries[reg_select_in[k]] | reg_in[k];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            for (int k = 0; k < SS; k++) begin
                out[k] <= entries[IDX_W'(tail_out + k)];
            end
        end
    end

    always_comb begin
        for (int k = 0; k < SS; k++) begin
            reg_out[k] = out_bitmask[k] ? entries[reg_select_out[k]] : QUEUE_TYPE'('0);
        end
    end

    assert property (@(posedge clk) disable iff (rst) push |-> !full)
        else $error("circular_queue: push while full");

    assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
        else $error("circular_queue: pop while empty");

endmodule

// File: src/commit_stage.sv
`timescale 1ns/10ps

module commit_stage #(
    parameter int unsigned SS = 2
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       rob_empty,
    input  core_types_pkg::rob_entry_t rob_tail_entries [SS],  // Oldest pair, observed
    input  core_types_pkg::rob_entry_t rob_out          [SS],  // Pair popped last cycle
    output logic                       rob_pop,
    input  logic                       fl_full,
    output logic                       fl_push,
    output core_types_pkg::phys_reg_t  fl_regs          [SS],
    output logic                       retire_valid,
    output core_types_pkg::retire_t    retire           [SS]
);
    import core_types_pkg::*;

    logic pair_done;
    logic pop_pending;   // Queue output lags the pop by a cycle

    always_comb begin
        pair_done = 1'b1;
        for (int k = 0; k < SS; k++) begin
            pair_done &= rob_tail_entries[k].done;
        end
    end

    assign rob_pop = !rob_empty && pair_done;

    always_ff @(posedge clk) begin
        if (rst) begin
            pop_pending <= 1'b0;
        end else begin
            pop_pending <= rob_pop;
        end
    end

    assign retire_valid = pop_pending;
    assign fl_push      = pop_pending;

    always_comb begin
        for (int k = 0; k < SS; k++) begin
            retire[k].arch_rd = rob_out[k].arch_rd;
            retire[k].phys    = rob_out[k].new_phys;
            fl_regs[k]        = rob_out[k].old_phys;
        end
    end

    // Registers in flight plus free ones never exceed the free-list size
    assert property (@(posedge clk) disable iff (rst) fl_push |-> !fl_full)
        else $error("commit_stage: free list full on release");

endmodule

// File: src/core_types_pkg.sv
package core_types_pkg;

    localparam int unsigned NUM_ARCH  = 32;
    localparam int unsigned NUM_PHYS  = 64;
    localparam int unsigned BUNDLE_W  = 2;    // Default bundle width
    localparam int unsigned ROB_IDX_W = 4;    // Sized for a 16-entry ROB

    typedef logic [$clog2(NUM_ARCH)-1:0] arch_reg_t;
    typedef logic [$clog2(NUM_PHYS)-1:0] phys_reg_t;
    typedef logic [ROB_IDX_W-1:0]        rob_idx_t;

    typedef enum logic [1:0] {
        OP_ALU,
        OP_LOAD,
        OP_STORE,
        OP_BRANCH
    } opcode_t;

    typedef struct packed {
        opcode_t   op;
        arch_reg_t rd;
        arch_reg_t rs1;
        arch_reg_t rs2;
    } instr_t;

    typedef instr_t [BUNDLE_W-1:0] dispatch_bundle_t;

    typedef struct packed {
        opcode_t   op;
        phys_reg_t prs1;
        phys_reg_t prs2;
        phys_reg_t prd;
        rob_idx_t  rob_idx;
    } renamed_instr_t;

    typedef renamed_instr_t [BUNDLE_W-1:0] renamed_bundle_t;

    typedef struct packed {
        arch_reg_t arch_rd;
        phys_reg_t new_phys;
        phys_reg_t old_phys;   // Returned to the free list at commit
        logic      done;
    } rob_entry_t;

    typedef struct packed {
        arch_reg_t arch_rd;
        phys_reg_t phys;
    } retire_t;

    // True when the instruction takes a new mapping for rd
    function automatic logic writes_rd(instr_t instr);
        return (instr.op inside {OP_ALU, OP_LOAD}) && (instr.rd != '0);
    endfunction

endpackage

// File: src/queue_pkg.sv
package queue_pkg;

    typedef enum logic {
        ZERO,
        FREE_LIST
    } initialization_t;

    function automatic int unsigned idx_width(int unsigned depth);
        return (depth > 1) ? $clog2(depth) : 1;
    endfunction

    // Index bits plus the wrap bit
    function automatic int unsigned ptr_width(int unsigned depth);
        return idx_width(depth) + 1;
    endfunction

endpackage

// File: src/rename_stage.sv
`timescale 1ns/10ps

module rename_stage #(
    parameter int unsigned SS = 2
) (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    dispatch_valid,
    output logic                                    dispatch_ready,
    input  core_types_pkg::instr_t [SS-1:0]         dispatch_bundle,
    input  core_types_pkg::phys_reg_t               fl_regs [SS],      // Free-list tail pair
    input  logic                                    fl_empty,
    output logic                                    fl_pop,
    input  logic                                    rob_full,
    input  core_types_pkg::rob_idx_t                rob_head,
    output logic                                    rob_push,
    output core_types_pkg::rob_entry_t              rob_entries [SS],
    output logic                                    renamed_valid,
    output core_types_pkg::renamed_instr_t [SS-1:0] renamed_bundle
);
    import core_types_pkg::*;

    phys_reg_t               rat     [NUM_ARCH];
    phys_reg_t               prs1    [SS];
    phys_reg_t               prs2    [SS];
    phys_reg_t               prev_rd [SS];   // Mapping of rd just before this slot
    logic                    accept;
    renamed_instr_t [SS-1:0] renamed_next;

    assign dispatch_ready = !rob_full && !fl_empty;
    assign accept         = dispatch_valid && dispatch_ready;
    assign fl_pop         = accept;
    assign rob_push       = accept;

    // RAT lookup, then bypass from older slots, youngest older slot last
    always_comb begin
        for (int k = 0; k < SS; k++) begin
            prs1[k]    = rat[dispatch_bundle[k].rs1];
            prs2[k]    = rat[dispatch_bundle[k].rs2];
            prev_rd[k] = rat[dispatch_bundle[k].rd];
            for (int j = 0; j < k; j++) begin
                if (writes_rd(dispatch_bundle[j])) begin
                    if (dispatch_bundle[j].rd == dispatch_bundle[k].rs1) begin
                        prs1[k] = fl_regs[j];
                    end
                    if (dispatch_bundle[j].rd == dispatch_bundle[k].rs2) begin
                        prs2[k] = fl_regs[j];
                    end
                    if (dispatch_bundle[j].rd == dispatch_bundle[k].rd) begin
                        prev_rd[k] = fl_regs[j];
                    end
                end
            end
        end
    end

    always_comb begin
        for (int k = 0; k < SS; k++) begin
            rob_entries[k].arch_rd  = dispatch_bundle[k].rd;
            rob_entries[k].new_phys = fl_regs[k];
            // Unused new register goes straight back at commit
            rob_entries[k].old_phys = writes_rd(dispatch_bundle[k]) ? prev_rd[k] : fl_regs[k];
            rob_entries[k].done     = 1'b0;

            renamed_next[k].op      = dispatch_bundle[k].op;
            renamed_next[k].prs1    = prs1[k];
            renamed_next[k].prs2    = prs2[k];
            renamed_next[k].prd     = fl_regs[k];
            renamed_next[k].rob_idx = rob_head + rob_idx_t'(k);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_ARCH; i++) begin
                rat[i] <= phys_reg_t'(i);   // Identity map
            end
        end else if (accept) begin
            for (int k = 0; k < SS; k++) begin
                if (writes_rd(dispatch_bundle[k])) begin
                    rat[dispatch_bundle[k].rd] <= fl_regs[k];  // Younger slot wins
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            renamed_valid <= 1'b0;
        end else begin
            renamed_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            renamed_bundle <= renamed_next;
        end
    end

    // Each slot gets its own register off the free list
    for (genvar k = 1; k < SS; k++) begin : g_alloc_check
        assert property (@(posedge clk) disable iff (rst) accept |-> fl_regs[k] != fl_regs[k-1])
            else $error("rename_stage: slot %0d shares a free register with slot %0d", k, k - 1);
    end

endmodule

// File: src/rename_top.sv
`timescale 1ns/10ps

module rename_top #(
    parameter int unsigned SS        = 2,
    parameter int unsigned ROB_DEPTH = 16,
    parameter int unsigned FL_DEPTH  = core_types_pkg::NUM_PHYS - core_types_pkg::NUM_ARCH
) (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    dispatch_valid,
    output logic                                    dispatch_ready,
    input  core_types_pkg::instr_t [SS-1:0]         dispatch_bundle,
    output logic                                    renamed_valid,
    output core_types_pkg::renamed_instr_t [SS-1:0] renamed_bundle,
    input  logic [SS-1:0]                           complete_valid,
    input  core_types_pkg::rob_idx_t                complete_idx [SS],
    output logic                                    retire_valid,
    output core_types_pkg::retire_t                 retire       [SS]
);
    import core_types_pkg::*;
    import queue_pkg::*;

    localparam int unsigned FL_IDX_W = idx_width(FL_DEPTH);

    logic                fl_empty;
    logic                fl_full;
    logic                fl_pop;
    logic                fl_push;
    logic [FL_IDX_W-1:0] fl_tail;
    logic [FL_IDX_W-1:0] fl_sel       [SS];
    phys_reg_t           fl_alloc     [SS];
    phys_reg_t           fl_freed     [SS];
    phys_reg_t           fl_no_mod    [SS];   // Free list is never modified in place

    logic                rob_empty;
    logic                rob_full;
    logic                rob_push;
    logic                rob_pop;
    rob_idx_t            rob_head;
    rob_idx_t            rob_tail;
    rob_idx_t            rob_sel      [SS];
    rob_entry_t          rob_in       [SS];
    rob_entry_t          rob_set_done [SS];
    rob_entry_t          rob_observed [SS];
    rob_entry_t          rob_out      [SS];

    if (idx_width(ROB_DEPTH) != ROB_IDX_W) begin : g_rob_check
        $error("rename_top: ROB_DEPTH does not match rob_idx_t");
    end

    assign fl_no_mod = '{default: '0};

    for (genvar k = 0; k < SS; k++) begin : g_slot
        assign fl_sel[k]       = fl_tail + FL_IDX_W'(k);
        assign rob_sel[k]      = rob_tail + rob_idx_t'(k);
        assign rob_set_done[k] = '{done: 1'b1, default: '0};
    end

    rename_stage #(.SS(SS)) i_rename_stage (
        .clk(clk), .rst(rst),
        .dispatch_valid(dispatch_valid), .dispatch_ready(dispatch_ready),
        .dispatch_bundle(dispatch_bundle),
        .fl_regs(fl_alloc), .fl_empty(fl_empty), .fl_pop(fl_pop),
        .rob_full(rob_full), .rob_head(rob_head),
        .rob_push(rob_push), .rob_entries(rob_in),
        .renamed_valid(renamed_valid), .renamed_bundle(renamed_bundle)
    );

    commit_stage #(.SS(SS)) i_commit_stage (
        .clk(clk), .rst(rst),
        .rob_empty(rob_empty), .rob_tail_entries(rob_observed), .rob_out(rob_out),
        .rob_pop(rob_pop), .fl_full(fl_full), .fl_push(fl_push), .fl_regs(fl_freed),
        .retire_valid(retire_valid), .retire(retire)
    );

    circular_queue #(
        .QUEUE_TYPE(phys_reg_t), .INIT_TYPE(FREE_LIST), .SS(SS), .DEPTH(FL_DEPTH)
    ) i_free_list (
        .clk(clk), .rst(rst), .push(fl_push), .pop(fl_pop),
        .in(fl_freed), .reg_in(fl_no_mod), .reg_select_in(fl_sel), .reg_select_out(fl_sel),
        .in_bitmask('0), .out_bitmask('1),
        .empty(fl_empty), .full(fl_full), .head_out(), .tail_out(fl_tail),
        .out(), .reg_out(fl_alloc)
    );

    circular_queue #(
        .QUEUE_TYPE(rob_entry_t), .INIT_TYPE(ZERO), .SS(SS), .DEPTH(ROB_DEPTH)
    ) i_rob (
        .clk(clk), .rst(rst), .push(rob_push), .pop(rob_pop),
        .in(rob_in), .reg_in(rob_set_done),
        .reg_select_in(complete_idx), .reg_select_out(rob_sel),
        .in_bitmask(complete_valid), .out_bitmask('1),
        .empty(rob_empty), .full(rob_full), .head_out(rob_head), .tail_out(rob_tail),
        .out(rob_out), .reg_out(rob_observed)
    );

endmodule

// File: tests/rename_model.svh
`ifndef RENAME_MODEL_SVH
`define RENAME_MODEL_SVH

phys_reg_t               rat_m    [NUM_ARCH];
phys_reg_t               fl_q     [$];          // Free registers, oldest first
arch_reg_t               rob_arch [ROB_DEPTH];
phys_reg_t               rob_new  [ROB_DEPTH];
phys_reg_t               rob_old  [ROB_DEPTH];
logic                    rob_done [ROB_DEPTH];
logic                    rob_pend [ROB_DEPTH];  // Completion driven, lands on the next edge
int unsigned             rob_wr;                // Next index written
int unsigned             rob_rd;                // Oldest index
int unsigned             rob_count;
renamed_instr_t [SS-1:0] exp_renamed;
retire_t                 exp_retire [SS];
phys_reg_t               exp_freed  [SS];

// Only ALU and load results take a new register, and x0 never does
function automatic logic maps_rd(instr_t ins);
    return (ins.op == OP_ALU || ins.op == OP_LOAD) && (ins.rd != 0);
endfunction

task automatic init_model();
    for (int i = 0; i < NUM_ARCH; i++) begin
        rat_m[i] = phys_reg_t'(i);
    end
    fl_q.delete();
    for (int i = 0; i < FL_DEPTH; i++) begin
        fl_q.push_back(phys_reg_t'(NUM_ARCH + i));
    end
    for (int i = 0; i < ROB_DEPTH; i++) begin
        rob_done[i] = 1'b0;
        rob_pend[i] = 1'b0;
    end
    rob_wr    = 0;
    rob_rd    = 0;
    rob_count = 0;
endtask

// Slots in order, sources read before the slot's own RAT write
task automatic rename_in_model(input instr_t [SS-1:0] bundle);
    phys_reg_t new_reg;
    for (int k = 0; k < SS; k++) begin
        new_reg                 = fl_q.pop_front();
        exp_renamed[k].op       = bundle[k].op;
        exp_renamed[k].prs1     = rat_m[bundle[k].rs1];
        exp_renamed[k].prs2     = rat_m[bundle[k].rs2];
        exp_renamed[k].prd      = new_reg;
        exp_renamed[k].rob_idx  = rob_idx_t'(rob_wr);
        rob_arch[rob_wr]        = bundle[k].rd;
        rob_new[rob_wr]         = new_reg;
        rob_done[rob_wr]        = 1'b0;
        rob_pend[rob_wr]        = 1'b0;
        if (maps_rd(bundle[k])) begin
            rob_old[rob_wr]     = rat_m[bundle[k].rd];
            rat_m[bundle[k].rd] = new_reg;
        end else begin
            rob_old[rob_wr]     = new_reg;    // Unused register goes back as itself
        end
        rob_wr    = (rob_wr + 1) % ROB_DEPTH;
        rob_count = rob_count + 1;
    end
endtask

function automatic logic oldest_pair_done();
    logic ok;
    ok = (rob_count >= SS);
    for (int k = 0; k < SS; k++) begin
        ok &= rob_done[(rob_rd + k) % ROB_DEPTH];
    end
    return ok;
endfunction

task automatic land_completions();
    for (int i = 0; i < ROB_DEPTH; i++) begin
        if (rob_pend[i]) begin
            rob_done[i] = 1'b1;
            rob_pend[i] = 1'b0;
        end
    end
endtask

task automatic take_oldest_pair();
    int unsigned idx;
    for (int k = 0; k < SS; k++) begin
        idx                   = (rob_rd + k) % ROB_DEPTH;
        exp_retire[k].arch_rd = rob_arch[idx];
        exp_retire[k].phys    = rob_new[idx];
        exp_freed[k]          = rob_old[idx];
    end
    rob_rd    = (rob_rd + SS) % ROB_DEPTH;
    rob_count = rob_count - SS;
endtask

`endif

// File: tests/rename_tb.sv
`timescale 1ns/10ps

module rename_tb;
    import core_types_pkg::*;

    localparam int unsigned SS            = 2;
    localparam int unsigned ROB_DEPTH     = 16;
    localparam int unsigned FL_DEPTH      = NUM_PHYS - NUM_ARCH;
    localparam int unsigned CLK_PERIOD    = 40;
    localparam int unsigned SEED          = 98;
    localparam int unsigned RESET_CYCLES  = 3;
    localparam int unsigned RANDOM_CYCLES = 400;
    localparam int unsigned DRAIN_CYCLES  = 100;
    localparam int unsigned STALL_CYCLES  = 40;    // Limit for each back-pressure step
    localparam int unsigned RUN_CYCLES    =
        RESET_CYCLES + RANDOM_CYCLES + 2 * DRAIN_CYCLES + 2 * STALL_CYCLES + 50;

    logic                    clk;
    logic                    rst;
    logic                    dispatch_valid;
    logic                    dispatch_ready;
    instr_t [SS-1:0]         dispatch_bundle;
    logic                    renamed_valid;
    renamed_instr_t [SS-1:0] renamed_bundle;
    logic [SS-1:0]           complete_valid;
    rob_idx_t                complete_idx [SS];
    logic                    retire_valid;
    retire_t                 retire       [SS];

    int unsigned checks;
    int unsigned errors;
    int unsigned dispatch_mode;    // 0 idle, 1 random, 2 every cycle
    logic        complete_on;
    logic        accept_prev;
    logic        pop_prev;
    logic        first_seen;
    int unsigned accepted_total;
    int unsigned renamed_total;
    int unsigned retired_total;
    int unsigned stall_accepts;
    int unsigned cycles;

    `include "rename_model.svh"

    rename_top #(.SS(SS), .ROB_DEPTH(ROB_DEPTH), .FL_DEPTH(FL_DEPTH)) i_rename_top (
        .clk(clk), .rst(rst),
        .dispatch_valid(dispatch_valid), .dispatch_ready(dispatch_ready),
        .dispatch_bundle(dispatch_bundle),
        .renamed_valid(renamed_valid), .renamed_bundle(renamed_bundle),
        .complete_valid(complete_valid), .complete_idx(complete_idx),
        .retire_valid(retire_valid), .retire(retire)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("ERROR %s: expected 0x%0h, actual 0x%0h at %0t",
                     name, expected, actual, $time);
        end
    endtask

    function automatic instr_t random_instr();
        instr_t ins;
        ins.op  = opcode_t'($urandom_range(0, 3));
        ins.rd  = arch_reg_t'($urandom_range(0, NUM_ARCH - 1));
        ins.rs1 = arch_reg_t'($urandom_range(0, NUM_ARCH - 1));
        ins.rs2 = arch_reg_t'($urandom_range(0, NUM_ARCH - 1));
        return ins;
    endfunction

    // Completions only target entries the model still holds as not done
    task automatic drive_inputs();
        int unsigned cand [$];
        int unsigned pick;
        int unsigned idx;
        dispatch_valid = (dispatch_mode == 2) ||
                         (dispatch_mode == 1 && $urandom_range(0, 99) < 70);
        for (int k = 0; k < SS; k++) begin
            dispatch_bundle[k] = random_instr();
        end
        complete_valid = '0;
        for (int k = 0; k < SS; k++) begin
            cand.delete();
            for (int i = 0; i < rob_count; i++) begin
                idx = (rob_rd + i) % ROB_DEPTH;
                if (!rob_done[idx] && !rob_pend[idx]) begin
                    cand.push_back(idx);
                end
            end
            if (complete_on && cand.size() > 0 && $urandom_range(0, 1) == 1) begin
                pick              = cand[$urandom_range(0, cand.size() - 1)];
                complete_valid[k] = 1'b1;
                complete_idx[k]   = rob_idx_t'(pick);
                rob_pend[pick]    = 1'b1;
            end
        end
    endtask

    // Runs mid-cycle, model mirrors the DUT state after the last edge
    task automatic evaluate_cycle();
        logic exp_ready;
        logic pop_now;
        logic accept_now;
        exp_ready = (rob_count + SS <= ROB_DEPTH) && (fl_q.size() >= SS);
        check_value("dispatch_ready", exp_ready, dispatch_ready);
        if (accept_prev && !renamed_valid) begin
            errors++;
            $display("Renamed bundle did not appear one cycle after acceptance at %0t", $time);
        end else begin
            check_value("renamed_valid", accept_prev, renamed_valid);
        end
        if (accept_prev && renamed_valid) begin
            renamed_total++;
            for (int k = 0; k < SS; k++) begin
                check_value($sformatf("renamed slot %0d", k), exp_renamed[k], renamed_bundle[k]);
            end
            if (!first_seen) begin
                check_value("first bundle prd slot 0", NUM_ARCH, renamed_bundle[0].prd);
                check_value("first bundle prd slot 1", NUM_ARCH + 1, renamed_bundle[1].prd);
                first_seen = 1'b1;
            end
        end
        if (pop_prev && !retire_valid) begin
            errors++;
            $display("Retire did not appear one cycle after the pair was done at %0t", $time);
        end else begin
            check_value("retire_valid", pop_prev, retire_valid);
        end
        if (pop_prev) begin
            if (retire_valid) begin
                retired_total++;
                for (int k = 0; k < SS; k++) begin
                    check_value($sformatf("retire slot %0d", k), exp_retire[k], retire[k]);
                end
            end
            for (int k = 0; k < SS; k++) begin
                fl_q.push_back(exp_freed[k]);
            end
        end
        pop_now    = oldest_pair_done();
        accept_now = dispatch_valid && exp_ready;
        if (accept_now) begin
            rename_in_model(dispatch_bundle);
            accepted_total++;
        end
        land_completions();
        if (pop_now) begin
            take_oldest_pair();
        end
        accept_prev = accept_now;
        pop_prev    = pop_now;
    endtask

    task automatic run_cycle();
        @(posedge clk);
        #2;
        drive_inputs();
        @(negedge clk);
        evaluate_cycle();
    endtask

    task automatic drain_rob();
        int unsigned n;
        dispatch_mode = 0;
        complete_on   = 1'b1;
        n             = 0;
        while ((rob_count != 0 || accept_prev || pop_prev) && n < DRAIN_CYCLES) begin
            run_cycle();
            n++;
        end
        if (rob_count != 0 || pop_prev) begin
            errors++;
            $display("ROB did not drain, %0d entries still waiting to retire", rob_count);
        end
    endtask

    initial begin
        #(RUN_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles before the run finished", RUN_CYCLES);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        rst             = 1'b1;
        dispatch_valid  = 1'b0;
        dispatch_bundle = '0;
        complete_valid  = '0;
        complete_idx    = '{default: '0};
        checks          = 0;
        errors          = 0;
        dispatch_mode   = 0;
        complete_on     = 1'b0;
        accept_prev     = 1'b0;
        pop_prev        = 1'b0;
        first_seen      = 1'b0;
        accepted_total  = 0;
        renamed_total   = 0;
        retired_total   = 0;
        init_model();
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;
        @(negedge clk);
        check_value("renamed_valid after reset", 0, renamed_valid);
        check_value("retire_valid after reset", 0, retire_valid);
        check_value("dispatch_ready after reset", 1, dispatch_ready);

        dispatch_mode = 1;
        complete_on   = 1'b1;
        repeat (RANDOM_CYCLES) run_cycle();
        drain_rob();

        // Completion held back, so the ROB fills and stalls dispatch
        dispatch_mode = 2;
        complete_on   = 1'b0;
        stall_accepts = 0;
        cycles        = 0;
        do begin
            run_cycle();
            if (accept_prev) stall_accepts++;
            cycles++;
        end while (dispatch_ready && cycles < STALL_CYCLES);
        if (dispatch_ready) begin
            errors++;
            $display("dispatch_ready never dropped while completion was withheld");
        end
        check_value("bundles accepted until ROB full", ROB_DEPTH / SS, stall_accepts);
        repeat (4) run_cycle();
        complete_on = 1'b1;
        cycles      = 0;
        do begin
            run_cycle();
            cycles++;
        end while (!dispatch_ready && cycles < STALL_CYCLES);
        if (!dispatch_ready) begin
            errors++;
            $display("dispatch_ready did not rise again after retirement");
        end
        repeat (10) run_cycle();
        drain_rob();

        check_value("renamed bundles", accepted_total, renamed_total);
        check_value("retired pairs", accepted_total, retired_total);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
